// File: spi_settings.svh
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// Register offsets on the APB bus
`define SPI_REG_CTRL   8'h00
`define SPI_REG_DIV    8'h04
`define SPI_REG_TXDATA 8'h08
`define SPI_REG_RXDATA 8'h0C
`define SPI_REG_STATUS 8'h10

// Half-period divider
`define SPI_DIV_W      8
`define SPI_DIV_RESET  3        // Gives sclk = clk / 8 out of reset

`endif

// File: apb_pkg.sv
package apb_pkg;

    // Request from the APB master
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // Response back to the master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

// File: spi_pkg.sv
`include "spi_settings.svh"

package spi_pkg;

    typedef struct packed {
        logic cpol;     // Idle level of sclk
        logic cpha;     // 0: sample on first edge, 1: on second edge
    } spi_mode_t;

    // Register block to engine
    typedef struct packed {
        logic                  start;   // One-cycle pulse
        logic [7:0]            tx_byte;
        spi_mode_t             mode;
        logic [`SPI_DIV_W-1:0] div;
    } spi_cmd_t;

    // Engine to register block
    typedef struct packed {
        logic       busy;
        logic       done;       // One-cycle pulse, rx_byte valid
        logic [7:0] rx_byte;
    } spi_stat_t;

    typedef struct packed {
        logic sclk;
        logic mosi;
        logic cs_n;
    } spi_pins_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LEAD,    // Next sclk edge is a leading one
        ST_TRAIL,   // Next sclk edge is a trailing one
        ST_DONE     // Last half-period before cs_n rises
    } engine_state_t;

endpackage

// File: spi_apb_regs.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_apb_regs (
    input  logic              clk,
    input  logic              rst,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp,
    output spi_pkg::spi_cmd_t cmd,
    input  spi_pkg::spi_stat_t stat
);

    import spi_pkg::*;

    logic access;               // APB access phase
    logic wr_en;
    logic rd_en;
    logic hit_ctrl;
    logic hit_div;
    logic hit_tx;
    logic hit_rx;
    logic hit_stat;
    logic hit_any;
    logic busy_any;
    logic accept_tx;
    logic err;
    logic [31:0] rdata;

    spi_mode_t             mode_q;
    logic [`SPI_DIV_W-1:0] div_q;
    logic [7:0]            tx_q;
    logic [7:0]            rx_q;
    logic                  rx_valid_q;
    logic                  start_q;

    assign access = apb_req.psel && apb_req.penable;
    assign wr_en  = access && apb_req.pwrite;
    assign rd_en  = access && !apb_req.pwrite;

    // Address decode
    assign hit_ctrl = (apb_req.paddr == `SPI_REG_CTRL);
    assign hit_div  = (apb_req.paddr == `SPI_REG_DIV);
    assign hit_tx   = (apb_req.paddr == `SPI_REG_TXDATA);
    assign hit_rx   = (apb_req.paddr == `SPI_REG_RXDATA);
    assign hit_stat = (apb_req.paddr == `SPI_REG_STATUS);
    assign hit_any  = hit_ctrl || hit_div || hit_tx || hit_rx || hit_stat;

    // Start pulse counts as busy, engine flag follows a cycle later
    assign busy_any  = stat.busy || start_q;
    assign accept_tx = wr_en && hit_tx && !busy_any;

    always_comb begin
        err = 1'b0;
        if (access) begin
            if (!hit_any) begin
                err = 1'b1;
            end else if (apb_req.pwrite && (hit_rx || hit_stat)) begin
                err = 1'b1;     // Read-only registers
            end else if (apb_req.pwrite && hit_tx && busy_any) begin
                err = 1'b1;     // Transfer in progress
            end
        end
    end

    // Read mux
    always_comb begin
        rdata = '0;
        if (rd_en && !err) begin
            case (apb_req.paddr)
                `SPI_REG_CTRL:   rdata = {30'b0, mode_q.cpha, mode_q.cpol};
                `SPI_REG_DIV:    rdata = 32'(div_q);
                `SPI_REG_TXDATA: rdata = {24'b0, tx_q};
                `SPI_REG_RXDATA: rdata = {24'b0, rx_q};
                `SPI_REG_STATUS: rdata = {30'b0, rx_valid_q, stat.busy};
                default:         rdata = '0;
            endcase
        end
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;      // No wait states
    assign apb_rsp.pslverr = err;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode_q     <= '0;
            div_q      <= `SPI_DIV_W'(`SPI_DIV_RESET);
            rx_valid_q <= 1'b0;
            start_q    <= 1'b0;
        end else begin
            start_q <= accept_tx;
            if (wr_en && hit_ctrl) begin
                mode_q.cpol <= apb_req.pwdata[0];
                mode_q.cpha <= apb_req.pwdata[1];
            end
            if (wr_en && hit_div) begin
                div_q <= apb_req.pwdata[`SPI_DIV_W-1:0];
            end
            // New byte wins over a read in the same cycle
            if (stat.done) begin
                rx_valid_q <= 1'b1;
            end else if (rd_en && hit_rx) begin
                rx_valid_q <= 1'b0;
            end
        end
    end

    // Data bytes
    always_ff @(posedge clk) begin
        if (accept_tx) begin
            tx_q <= apb_req.pwdata[7:0];
        end
        if (stat.done) begin
            rx_q <= stat.rx_byte;
        end
    end

    assign cmd.start   = start_q;
    assign cmd.tx_byte = tx_q;
    assign cmd.mode    = mode_q;
    assign cmd.div     = div_q;

endmodule

// File: spi_byte_engine.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_byte_engine (
    input  logic               clk,
    input  logic               rst,
    input  spi_pkg::spi_cmd_t  cmd,
    output spi_pkg::spi_stat_t stat,
    input  logic               miso,
    output spi_pkg::spi_pins_t pins
);

    import spi_pkg::*;

    engine_state_t         state_q;
    spi_mode_t             mode_q;      // Frozen for the whole transfer
    logic [`SPI_DIV_W-1:0] div_q;
    logic [`SPI_DIV_W-1:0] cnt_q;       // Half-period countdown
    logic [2:0]            bit_cnt_q;
    logic                  sclk_q;
    logic                  cs_n_q;
    logic                  mosi_q;
    logic                  done_q;
    logic [7:0]            tx_sr;
    logic [7:0]            rx_sr;

    logic tick;
    logic launch;
    logic lead_edge;
    logic trail_edge;
    logic sample_edge;
    logic shift_edge;

    assign tick       = (cnt_q == '0);
    assign launch     = (state_q == ST_IDLE) && cmd.start;
    assign lead_edge  = (state_q == ST_LEAD) && tick;
    assign trail_edge = (state_q == ST_TRAIL) && tick;

    // cpha picks which edge samples and which one shifts
    assign sample_edge = mode_q.cpha ? trail_edge : lead_edge;
    assign shift_edge  = mode_q.cpha ? lead_edge : trail_edge;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            mode_q    <= '0;
            div_q     <= '0;
            cnt_q     <= '0;
            bit_cnt_q <= '0;
            sclk_q    <= 1'b0;
            cs_n_q    <= 1'b1;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (state_q != ST_IDLE) begin
                cnt_q <= tick ? div_q : cnt_q - 1'b1;
            end
            case (state_q)
                ST_IDLE: begin
                    // Idle level tracks CTRL so sclk is settled before cs_n falls
                    mode_q <= cmd.mode;
                    sclk_q <= cmd.mode.cpol;
                    if (cmd.start) begin
                        div_q     <= cmd.div;
                        cnt_q     <= cmd.div;
                        bit_cnt_q <= '0;
                        cs_n_q    <= 1'b0;
                        state_q   <= ST_LEAD;
                    end
                end
                ST_LEAD: begin
                    if (tick) begin
                        sclk_q  <= ~sclk_q;
                        state_q <= ST_TRAIL;
                    end
                end
                ST_TRAIL: begin
                    if (tick) begin
                        sclk_q    <= ~sclk_q;
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        state_q   <= (bit_cnt_q == 3'd7) ? ST_DONE : ST_LEAD;
                    end
                end
                ST_DONE: begin
                    if (tick) begin     // One idle half-period after edge 16
                        cs_n_q  <= 1'b1;
                        done_q  <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Serial output bit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mosi_q <= 1'b0;
        end else if (launch && !cmd.mode.cpha) begin
            mosi_q <= cmd.tx_byte[7];   // MSB ready before first edge
        end else if (shift_edge) begin
            mosi_q <= tx_sr[7];
        end
    end

    // Shift registers, MSB first
    always_ff @(posedge clk) begin
        if (launch) begin
            tx_sr <= cmd.mode.cpha ? cmd.tx_byte : {cmd.tx_byte[6:0], 1'b0};
        end else if (shift_edge) begin
            tx_sr <= {tx_sr[6:0], 1'b0};
        end
        if (sample_edge) begin
            rx_sr <= {rx_sr[6:0], miso};
        end
    end

    always_comb begin
        stat.busy    = (state_q != ST_IDLE);
        stat.done    = done_q;
        stat.rx_byte = rx_sr;
        pins.sclk    = sclk_q;
        pins.mosi    = mosi_q;
        pins.cs_n    = cs_n_q;
    end

endmodule

// File: spi_master_top.sv
`timescale 1ns/1ps

module spi_master_top (
    input  logic               clk,
    input  logic               rst,
    input  apb_pkg::apb_req_t  apb_req,
    output apb_pkg::apb_rsp_t  apb_rsp,
    input  logic               miso,
    output spi_pkg::spi_pins_t spi_pins
);

    import spi_pkg::*;

    spi_cmd_t  cmd;     // Register block to engine
    spi_stat_t stat;    // Engine back to registers

    // APB register front end
    spi_apb_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .cmd     (cmd),
        .stat    (stat)
    );

    // Serial clock and shift engine
    spi_byte_engine u_engine (
        .clk  (clk),
        .rst  (rst),
        .cmd  (cmd),
        .stat (stat),
        .miso (miso),
        .pins (spi_pins)
    );

endmodule

// File: spi_master_checker.sv
`timescale 1ns/1ps

module spi_master_checker (
    input logic               clk,
    input logic               rst,
    input apb_pkg::apb_rsp_t  apb_rsp,
    input spi_pkg::spi_pins_t spi_pins,
    input spi_pkg::spi_cmd_t  cmd
);

    int fail_count = 0;     // Assertion failures so far

    // Idle cs_n only falls on a start command
    cs_idle_high: assert property (@(posedge clk) disable iff (rst)
        spi_pins.cs_n && !cmd.start |=> spi_pins.cs_n)
        else begin
            $error("cs_n fell while idle without a start command");
            fail_count++;
        end

    pready_high: assert property (@(posedge clk) disable iff (rst) apb_rsp.pready)
        else begin
            $error("pready is low");
            fail_count++;
        end

    // Between transfers sclk only follows the programmed idle level
    sclk_quiet: assert property (@(posedge clk) disable iff (rst)
        spi_pins.cs_n && $past(spi_pins.cs_n) |-> spi_pins.sclk == $past(cmd.mode.cpol))
        else begin
            $error("sclk moved while cs_n was high");
            fail_count++;
        end

    // Leading edge samples when cpha is 0 and trailing edge when cpha is 1
    mosi_stable: assert property (@(posedge clk) disable iff (rst)
        !spi_pins.cs_n && $changed(spi_pins.sclk)
            && ((spi_pins.sclk ^ cmd.mode.cpol) != cmd.mode.cpha)
        |-> $stable(spi_pins.mosi))
        else begin
            $error("mosi changed on a sample edge");
            fail_count++;
        end

endmodule

bind spi_master_top spi_master_checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .apb_rsp  (apb_rsp),
    .spi_pins (spi_pins),
    .cmd      (cmd)
);

// File: tb_spi_master.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module tb_spi_master;

    import apb_pkg::*;
    import spi_pkg::*;

    localparam int POLL_LIMIT = 200;

    typedef struct packed {
        logic [7:0] master_rx;
        logic [7:0] slave_rx;
        logic       sclk_idle;
    } exchange_t;

    typedef struct packed {
        spi_mode_t  mode;
        logic [7:0] master_tx;
        logic [7:0] slave_tx;
        logic [7:0] slave_got;
        logic [7:0] rxdata;
        logic       sclk_idle;
    } result_t;

    logic      clk;
    logic      rst;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    logic      miso = 1'b0;
    spi_pins_t spi_pins;

    int          errors = 0;
    int          failures = 0;
    logic [31:0] rng_state = 32'hf3435a9b;
    result_t     results[$];

    // Slave model state
    spi_mode_t   slv_mode = '0;
    logic [7:0]  slv_tx = '0;
    logic [7:0]  slv_shift = '0;
    logic [7:0]  slv_rx = '0;
    logic [7:0]  slv_captured = '0;
    logic [7:0]  cur_div = 8'(`SPI_DIV_RESET);
    int          slv_edges = 0;
    int          slv_gap = 0;
    int          slv_xfers = 0;
    logic        cs_prev = 1'b1;
    logic        sclk_prev = 1'b0;

    spi_master_top uut (
        .clk      (clk),
        .rst      (rst),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .miso     (miso),
        .spi_pins (spi_pins)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] next_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[7:0];
    endfunction

    // Full duplex, MSB first: each side ends up with the other side's byte
    function automatic exchange_t expect_exchange(input logic [7:0] master_tx,
                                                  input logic [7:0] slave_tx,
                                                  input spi_mode_t  mode);
        exchange_t e;
        e = '0;
        for (int i = 7; i >= 0; i--) begin
            e.slave_rx  = {e.slave_rx[6:0], master_tx[i]};
            e.master_rx = {e.master_rx[6:0], slave_tx[i]};
        end
        e.sclk_idle = mode.cpol;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error at time %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Failure at time %0t: %s", $time, what);
            failures++;
        end
    endtask

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int n;
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;     // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        n = 0;
        @(negedge clk);
        while (!apb_rsp.pready && n < 16) begin
            @(negedge clk);
            n++;
        end
        check_true(apb_rsp.pready, "APB access never completed");
        rdata = apb_rsp.prdata;     // Mid-cycle of the access phase
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
        apb_access(1'b1, addr, wdata, rdata, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata,
                            output logic err);
        apb_access(1'b0, addr, 32'h0, rdata, err);
    endtask

    task automatic wait_idle(output logic saw_busy);
        logic [31:0] rd;
        logic        err;
        int          n;
        n = 0;
        apb_read(`SPI_REG_STATUS, rd, err);
        saw_busy = rd[0];
        while (rd[0] && n < POLL_LIMIT) begin
            apb_read(`SPI_REG_STATUS, rd, err);
            n++;
        end
        check_true(!rd[0], "timeout waiting for the busy flag to clear");
    endtask

    task automatic wait_cs_low();
        int n;
        n = 0;
        while (spi_pins.cs_n && n < POLL_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        check_true(!spi_pins.cs_n, "timeout waiting for cs_n to fall");
    endtask

    task automatic run_transfer(input spi_mode_t mode, input logic [7:0] div,
                                input logic overlap);
        logic [31:0] rd;
        logic        err;
        logic        saw_busy;
        logic [7:0]  mtx;
        int          xfers;
        result_t     r;
        mtx      = next_byte();
        slv_tx   = next_byte();
        slv_mode = mode;
        cur_div  = div;
        apb_write(`SPI_REG_CTRL, {30'b0, mode.cpha, mode.cpol}, rd, err);
        check_value("pslverr on CTRL write", 0, 32'(err));
        apb_write(`SPI_REG_DIV, 32'(div), rd, err);
        check_value("pslverr on DIV write", 0, 32'(err));
        xfers = slv_xfers;
        apb_write(`SPI_REG_TXDATA, 32'(mtx), rd, err);
        check_value("pslverr on TXDATA write", 0, 32'(err));
        if (overlap) begin
            wait_cs_low();
            apb_write(`SPI_REG_TXDATA, 32'(~mtx), rd, err);
            check_value("pslverr on TXDATA write while busy", 1, 32'(err));
            check_value("prdata on refused TXDATA write", 0, rd);
        end
        wait_idle(saw_busy);
        check_true(saw_busy, "busy flag not set after TXDATA write");
        check_value("transfers seen by slave model", 32'(xfers + 1), 32'(slv_xfers));
        apb_read(`SPI_REG_STATUS, rd, err);
        check_value("STATUS after transfer", 32'h2, rd);
        apb_read(`SPI_REG_TXDATA, rd, err);
        check_value("TXDATA readback", 32'(mtx), rd);
        r.mode      = mode;
        r.master_tx = mtx;
        r.slave_tx  = slv_tx;
        r.slave_got = slv_captured;
        r.sclk_idle = spi_pins.sclk;
        apb_read(`SPI_REG_RXDATA, rd, err);
        r.rxdata = rd[7:0];
        results.push_back(r);
        apb_read(`SPI_REG_STATUS, rd, err);
        check_value("STATUS after RXDATA read", 0, rd);     // Also no second transfer
    endtask

    // SPI slave model, looks at the pins 1 ns after each rising edge
    always @(posedge clk) begin
        #1;
        if (!rst) begin
            if (cs_prev && !spi_pins.cs_n) begin
                slv_shift = slv_tx;
                slv_rx    = '0;
                slv_edges = 0;
                slv_gap   = 0;
                if (!slv_mode.cpha) begin
                    miso      = slv_shift[7];   // First bit out before any edge
                    slv_shift = slv_shift << 1;
                end
            end else if (!spi_pins.cs_n) begin
                slv_gap++;
                if (spi_pins.sclk != sclk_prev) begin
                    slv_edges++;
                    check_value("sclk half-period in clk cycles",
                                32'(cur_div) + 1, 32'(slv_gap));
                    slv_gap = 0;
                    if ((spi_pins.sclk != slv_mode.cpol) != slv_mode.cpha) begin
                        slv_rx = {slv_rx[6:0], spi_pins.mosi};
                    end else begin
                        miso      = slv_shift[7];
                        slv_shift = slv_shift << 1;
                    end
                end
            end else if (!cs_prev) begin
                check_value("sclk edges per transfer", 16, 32'(slv_edges));
                check_value("idle half-period before cs_n rises",
                            32'(cur_div) + 1, 32'(slv_gap + 1));
                slv_captured = slv_rx;
                slv_xfers++;
            end
            cs_prev   = spi_pins.cs_n;
            sclk_prev = spi_pins.sclk;
        end
    end

    always @(posedge clk) begin : compare
        result_t   r;
        exchange_t e;
        #2;
        if (results.size() > 0) begin
            r = results.pop_front();
            e = expect_exchange(r.master_tx, r.slave_tx, r.mode);
            check_value("slave model rx byte", 32'(e.slave_rx), 32'(r.slave_got));
            check_value("RXDATA", 32'(e.master_rx), 32'(r.rxdata));
            check_value("sclk idle level", 32'(e.sclk_idle), 32'(r.sclk_idle));
        end
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        int          n;
        rst     = 1'b1;
        apb_req = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        check_value("cs_n after reset", 1, 32'(spi_pins.cs_n));
        check_value("sclk after reset", 0, 32'(spi_pins.sclk));
        check_value("mosi after reset", 0, 32'(spi_pins.mosi));
        apb_read(`SPI_REG_STATUS, rd, err);
        check_value("STATUS after reset", 0, rd);
        apb_read(`SPI_REG_CTRL, rd, err);
        check_value("CTRL after reset", 0, rd);
        apb_read(`SPI_REG_DIV, rd, err);
        check_value("DIV after reset", `SPI_DIV_RESET, rd);

        for (int m = 0; m < 4; m++) begin
            run_transfer(spi_mode_t'(m[1:0]), 8'd0, 1'b0);
            run_transfer(spi_mode_t'(m[1:0]), 8'd1, 1'b0);
            run_transfer(spi_mode_t'(m[1:0]), 8'd3, 1'b0);
        end
        run_transfer(spi_mode_t'(2'b11), 8'd3, 1'b1);   // Refused write mid-transfer

        apb_read(8'h14, rd, err);
        check_value("pslverr on unmapped read", 1, 32'(err));
        check_value("prdata on unmapped read", 0, rd);
        apb_write(`SPI_REG_RXDATA, 32'h5a, rd, err);
        check_value("pslverr on RXDATA write", 1, 32'(err));
        check_value("prdata on RXDATA write", 0, rd);
        apb_write(`SPI_REG_STATUS, 32'h3, rd, err);
        check_value("pslverr on STATUS write", 1, 32'(err));
        check_value("prdata on STATUS write", 0, rd);

        n = 0;
        while (results.size() > 0 && n < 100) begin
            @(posedge clk);
            n++;
        end
        check_true(results.size() == 0, "compare process left results unchecked");
        failures += uut.u_checker.fail_count;

        $display("Done: %0d value errors, %0d other failures", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
apb_pkg.sv
spi_pkg.sv
spi_apb_regs.sv
spi_byte_engine.sv
spi_master_top.sv
spi_master_checker.sv
tb_spi_master.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_spi_master
RTL_TOP    := spi_master_top
FILELIST   := sim.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert
RUN_ARGS   := +verilator+error+limit+100
LOG        := sim.log
PASS_MSG   := test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
